// File: test/mmu_patterns.txt
# M addr word
# T name satp priv sum access va pa fault reads (hex except reads)
# level 1 table at 0x100000
M 100000 00040401
M 100004 003000CB
M 100008 003004CB
M 10000C 00000000
# level 0 table at 0x101000
M 101004 048D14C7
M 101008 00000000
M 10100C 002AA8DF
M 101010 002EEC43
M 101014 00333087
M 101018 00377447
M 10101C 003BB801
M 101024 000804C7
M 101028 000808C7
M 10102C 00080CC7
M 101030 000810C7
T bypass_bare 00000100 1 0 0 DEADBEEF 0DEADBEEF 0 0
T bypass_machine 80000100 3 0 1 00001123 000001123 0 0
T walk_4k_load 80000100 1 0 0 00001123 012345123 0 2
T hit_repeat 80000100 1 0 0 00001123 012345123 0 0
T hit_offset 80000100 1 0 1 00001ABC 012345ABC 0 0
T super_fetch 80000100 1 0 2 00555010 000D55010 0 1
T super_misaligned 80000100 1 0 0 00800234 000000000 2 1
T invalid_l1 80000100 1 0 0 00C00000 000000000 1 1
T invalid_l0 80000100 1 0 0 00002000 000000000 1 2
T pointer_at_l0 80000100 1 0 0 00007000 000000000 1 2
T user_non_u 80000100 0 0 0 00001123 000000000 3 0
T super_u_no_sum 80000100 1 0 0 00003010 000000000 3 2
T super_u_sum 80000100 1 1 0 00003010 000AAA010 0 0
T super_fetch_u 80000100 1 1 2 00003010 000000000 3 0
T store_read_only 80000100 1 0 1 00004008 000000000 4 2
T store_ro_again 80000100 1 0 1 00004008 000000000 4 0
T fetch_no_x 80000100 1 0 2 00004008 000000000 4 0
T load_read_only 80000100 1 0 0 00004008 000BBB008 0 0
T a_clear 80000100 1 0 0 00005000 000000000 5 2
T store_d_clear 80000100 1 0 1 00006004 000000000 5 2
T priv_over_perm 80000100 0 0 1 00004008 000000000 3 0
F
T flush_rewalk 80000100 1 0 0 00001123 012345123 0 2
T rr_page_a 80000100 1 0 0 00009000 000201000 0 2
T rr_page_b 80000100 1 0 0 0000A000 000202000 0 2
T rr_page_c 80000100 1 0 0 0000B000 000203000 0 2
T rr_page_d 80000100 1 0 0 0000C000 000204000 0 2
T rr_evicted 80000100 1 0 0 00001123 012345123 0 2
T rr_kept 80000100 1 0 0 0000C010 000204010 0 0

// File: tb.f
+incdir+hw
hw/mmu_pkg.sv
hw/pte_checker.sv
hw/mmu_tlb.sv
hw/sv32_walker.sv
hw/mmu_top.sv
test/mmu_assert.sv
test/mmu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mmu_tb -f tb.f -o mmu_sim
out=$(./obj_dir/mmu_sim)
echo "$out"
if echo "$out" | grep -q "Regression passed"; then
    exit 0
else
    exit 1
fi

// File: test/mmu_tb.sv
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mmu_tb;
    import mmu_pkg::*;

    typedef struct packed {
        logic       is_flush;
        xlate_req_t req;
        xlate_rsp_t exp;
        logic [7:0] reads;
    } vec_t;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    xlate_req_t           req;
    logic                 flush;
    logic                 rsp_valid;
    xlate_rsp_t           rsp;
    logic                 busy;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic [`MMU_PA_W-1:0] wb_adr;
    logic                 wb_ack;
    pte_t                 wb_dat;

    logic [31:0] mem_words [logic [`MMU_PA_W-1:0]];
    vec_t        vecs[$];
    string       names[$];
    logic [31:0] lfsr = 32'h8f80_d3e0;
    int          wait_left = -1;
    int          read_count = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          rsp_errors = 0;
    int          read_errors = 0;
    int          file_errors = 0;

    mmu_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] mem_read(input logic [`MMU_PA_W-1:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return 32'h0;
    endfunction

    // wishbone slave with 0 to 3 wait states
    always @(posedge clk) begin
        if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_left < 0) begin
                lfsr = lfsr_step(lfsr);
                wait_left = lfsr[0];
                lfsr = lfsr_step(lfsr);
                wait_left = wait_left * 2 + lfsr[0];
            end
            if (wait_left == 0) begin
                wb_ack     <= 1'b1;
                wb_dat     <= pte_t'(mem_read(wb_adr));
                read_count = read_count + 1;
                wait_left  = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout: no response after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_rsp(input string name, input xlate_rsp_t exp, input xlate_rsp_t act);
        // pa only means something without a fault
        if (act.fault != exp.fault || (exp.fault == FAULT_NONE && act.pa != exp.pa)) begin
            rsp_errors++;
            $display("FAILED %s: expected pa=%h fault=%0d, actual pa=%h fault=%0d",
                     name, exp.pa, exp.fault, act.pa, act.fault);
        end
    endtask

    task automatic check_reads(input string name, input int exp, input int act);
        if (exp != act) begin
            read_errors++;
            $display("FAILED %s: expected reads=%0d, actual reads=%0d", name, exp, act);
        end
    endtask

    task automatic load_patterns();
        int          fd;
        string       kind;
        string       line;
        string       name;
        logic [33:0] addr;
        logic [33:0] pa;
        logic [31:0] word;
        logic [31:0] satp;
        logic [31:0] va;
        logic [3:0]  priv;
        logic [3:0]  sum;
        logic [3:0]  acc;
        logic [3:0]  fault;
        int          reads;
        vec_t        v;
        fd = $fopen("test/mmu_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/mmu_patterns.txt");
            file_errors++;
            return;
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            v = '0;
            if (kind == "M") begin
                void'($fscanf(fd, "%h %h", addr, word));
                mem_words[addr] = word;
            end else if (kind == "F") begin
                v.is_flush = 1'b1;
                vecs.push_back(v);
                names.push_back("flush");
            end else if (kind == "T") begin
                void'($fscanf(fd, "%s %h %h %h %h %h %h %h %d",
                              name, satp, priv, sum, acc, va, pa, fault, reads));
                v.req.va     = va;
                v.req.access = access_t'(acc[1:0]);
                v.req.priv   = priv_t'(priv[1:0]);
                v.req.satp   = satp;
                v.req.sum    = sum[0];
                v.exp.pa     = pa;
                v.exp.fault  = fault_t'(fault[2:0]);
                v.reads      = 8'(reads);
                vecs.push_back(v);
                names.push_back(name);
            end else begin
                void'($fgets(line, fd));
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input string name, input vec_t v);
        xlate_rsp_t got;
        read_count = 0;
        @(posedge clk);
        req       <= v.req;
        req_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!rsp_valid);
        got = rsp;
        req_valid <= 1'b0;
        check_rsp(name, v.exp, got);
        check_reads(name, int'(v.reads), read_count);
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        flush     = 1'b0;
        wb_ack    = 1'b0;
        wb_dat    = '0;
        load_patterns();
        cycle_limit = vecs.size() * 20 + 100;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        foreach (vecs[i]) begin
            if (vecs[i].is_flush) begin
                @(posedge clk);
                flush <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
            end else begin
                run_test(names[i], vecs[i]);
            end
        end
        repeat (2) @(posedge clk);
        $display("errors: response %0d, read count %0d, pattern file %0d",
                 rsp_errors, read_errors, file_errors);
        if (rsp_errors == 0 && read_errors == 0 && file_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: test/mmu_assert.sv
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mmu_assert (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 req_valid,
    input logic                 wb_cyc,
    input logic                 wb_stb,
    input logic [`MMU_PA_W-1:0] wb_adr,
    input logic                 wb_ack,
    input logic                 rsp_valid,
    input logic                 busy
);

    // cyc and stb drop in the cycle after ack
    cyc_ends_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && wb_ack) |=> (!wb_cyc && !wb_stb))
        else $error("wb_cyc or wb_stb still high after wb_ack");

    // classic cycle holds until the slave answers
    stb_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else $error("wb_stb or wb_adr changed before wb_ack");

    rsp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid longer than one cycle");

    busy_on_accept: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && !busy) |=> busy)
        else $error("busy low in the cycle after a request was accepted");

    busy_through_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> (busy ##1 !busy))
        else $error("busy not high with rsp_valid or not low after it");

endmodule

bind mmu_top mmu_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_ack    (wb_ack),
    .rsp_valid (rsp_valid),
    .busy      (busy)
);

// File: hw/mmu_top.sv
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mmu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  mmu_pkg::xlate_req_t  req,
    input  logic                 flush,
    output logic                 rsp_valid,
    output mmu_pkg::xlate_rsp_t  rsp,
    output logic                 busy,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic [`MMU_PA_W-1:0] wb_adr,
    input  logic                 wb_ack,
    input  mmu_pkg::pte_t        wb_dat
);
    import mmu_pkg::*;

    logic [2*`MMU_VPN_W-1:0] lookup_vpn;
    logic                    hit;
    tlb_entry_t              hit_entry;
    logic                    fill_valid;
    tlb_entry_t              fill_entry;

    sv32_walker u_walker (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .busy       (busy),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_ack     (wb_ack),
        .wb_dat     (wb_dat),
        .lookup_vpn (lookup_vpn),
        .hit        (hit),
        .hit_entry  (hit_entry),
        .fill_valid (fill_valid),
        .fill_entry (fill_entry)
    );

    mmu_tlb u_tlb (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .lookup_vpn (lookup_vpn),
        .hit        (hit),
        .hit_entry  (hit_entry),
        .fill_valid (fill_valid),
        .fill_entry (fill_entry)
    );

endmodule

// File: hw/sv32_walker.sv
`timescale 1ns/1ps
`include "mmu_consts.svh"

module sv32_walker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  mmu_pkg::xlate_req_t     req,
    output logic                    rsp_valid,
    output mmu_pkg::xlate_rsp_t     rsp,
    output logic                    busy,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic [`MMU_PA_W-1:0]    wb_adr,
    input  logic                    wb_ack,
    input  mmu_pkg::pte_t           wb_dat,
    output logic [2*`MMU_VPN_W-1:0] lookup_vpn,
    input  logic                    hit,
    input  mmu_pkg::tlb_entry_t     hit_entry,
    output logic                    fill_valid,
    output mmu_pkg::tlb_entry_t     fill_entry
);
    import mmu_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FETCH1,
        EXAM1,
        FETCH0,
        CHECK,
        RESP
    } state_t;

    state_t                  state_q;
    xlate_req_t              req_q;
    pte_t                    pte_q;
    logic                    super_q;
    logic                    bypass_q;
    logic                    walk_q;
    logic                    translate;
    logic                    is_pointer;
    logic                    fill_ok;
    logic [`MMU_VPN_W-1:0]   vpn1;
    logic [`MMU_VPN_W-1:0]   vpn0;
    logic [`MMU_PA_W-1:0]    l1_addr;
    logic [`MMU_PA_W-1:0]    l0_addr;
    fault_t                  chk_fault;
    logic [`MMU_PA_W-1:0]    chk_pa;

    assign vpn1 = req_q.va[`MMU_VA_W-1:`MMU_VA_W-`MMU_VPN_W];
    assign vpn0 = req_q.va[`MMU_VPN_W+`MMU_PG_OFF_W-1:`MMU_PG_OFF_W];

    assign translate = req_q.satp[`MMU_SATP_MODE] && (req_q.priv != PRIV_MACHINE);

    // base is page aligned and index*4 fits in the offset, so concat works
    assign l1_addr = {req_q.satp[`MMU_PPN_W-1:0], vpn1, 2'b00};
    assign l0_addr = {pte_q.ppn, vpn0, 2'b00};

    // valid non-leaf entry at level 1
    assign is_pointer = pte_q.v && !pte_q.r && !pte_q.w && !pte_q.x;

    assign fill_ok = (chk_fault != FAULT_INVALID) && (chk_fault != FAULT_MISALIGNED);

    assign lookup_vpn = req_q.va[`MMU_VA_W-1:`MMU_PG_OFF_W];

    assign wb_cyc = (state_q == FETCH1) || (state_q == FETCH0);
    assign wb_stb = wb_cyc;
    assign wb_adr = (state_q == FETCH0) ? l0_addr : l1_addr;

    assign busy = state_q != IDLE;

    pte_checker u_checker (
        .pte       (pte_q),
        .superpage (super_q),
        .access    (req_q.access),
        .priv      (req_q.priv),
        .sum       (req_q.sum),
        .va        (req_q.va),
        .fault     (chk_fault),
        .pa        (chk_pa)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            rsp_valid  <= 1'b0;
            fill_valid <= 1'b0;
            bypass_q   <= 1'b0;
            walk_q     <= 1'b0;
        end else begin
            rsp_valid  <= 1'b0;
            fill_valid <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (req_valid) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    bypass_q <= !translate;
                    walk_q   <= translate && !hit;
                    if (!translate || hit) begin
                        state_q <= CHECK;
                    end else begin
                        state_q <= FETCH1;
                    end
                end
                FETCH1: begin
                    if (wb_ack) begin
                        state_q <= EXAM1;
                    end
                end
                EXAM1: begin
                    // leaves and broken entries go straight to the checker
                    if (is_pointer) begin
                        state_q <= FETCH0;
                    end else begin
                        state_q <= CHECK;
                    end
                end
                FETCH0: begin
                    if (wb_ack) begin
                        state_q <= CHECK;
                    end
                end
                CHECK: begin
                    rsp_valid  <= 1'b1;
                    fill_valid <= walk_q && fill_ok;
                    state_q    <= RESP;
                end
                RESP: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (req_valid) begin
                    req_q <= req;
                end
            end
            LOOKUP: begin
                pte_q   <= hit_entry.pte;
                super_q <= hit_entry.superpage;
            end
            FETCH1: begin
                if (wb_ack) begin
                    pte_q   <= wb_dat;
                    super_q <= 1'b1;
                end
            end
            FETCH0: begin
                if (wb_ack) begin
                    pte_q   <= wb_dat;
                    super_q <= 1'b0;
                end
            end
            CHECK: begin
                if (bypass_q) begin
                    rsp.pa    <= {{(`MMU_PA_W-`MMU_VA_W){1'b0}}, req_q.va};
                    rsp.fault <= FAULT_NONE;
                end else begin
                    rsp.pa    <= chk_pa;
                    rsp.fault <= chk_fault;
                end
                fill_entry.valid     <= 1'b1;
                fill_entry.vpn       <= lookup_vpn;
                fill_entry.superpage <= super_q;
                fill_entry.pte       <= pte_q;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: hw/mmu_tlb.sv
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mmu_tlb (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [2*`MMU_VPN_W-1:0] lookup_vpn,
    output logic                    hit,
    output mmu_pkg::tlb_entry_t     hit_entry,
    input  logic                    fill_valid,
    input  mmu_pkg::tlb_entry_t     fill_entry
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(`MMU_TLB_ENTRIES);

    tlb_entry_t                  ent_q [`MMU_TLB_ENTRIES];
    logic [`MMU_TLB_ENTRIES-1:0] valid_q;
    logic [IDX_W-1:0]            rr_q;
    logic [IDX_W-1:0]            hit_idx;
    logic [IDX_W-1:0]            fill_hit_idx;
    logic [IDX_W-1:0]            fill_idx;
    logic                        fill_hit;

    // superpages only look at vpn1
    function automatic logic entry_match(input tlb_entry_t e,
                                         input logic [2*`MMU_VPN_W-1:0] vpn);
        logic vpn1_eq;
        logic vpn0_eq;
        vpn1_eq = e.vpn[2*`MMU_VPN_W-1:`MMU_VPN_W] == vpn[2*`MMU_VPN_W-1:`MMU_VPN_W];
        vpn0_eq = e.vpn[`MMU_VPN_W-1:0] == vpn[`MMU_VPN_W-1:0];
        return vpn1_eq && (e.superpage || vpn0_eq);
    endfunction

    // walk downwards so the lowest matching index wins
    always_comb begin
        hit          = 1'b0;
        hit_idx      = '0;
        fill_hit     = 1'b0;
        fill_hit_idx = '0;
        for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (valid_q[i] && entry_match(ent_q[i], lookup_vpn)) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
            if (valid_q[i] && entry_match(ent_q[i], fill_entry.vpn)) begin
                fill_hit     = 1'b1;
                fill_hit_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        hit_entry       = ent_q[hit_idx];
        hit_entry.valid = hit;
    end

    // overwrite a matching entry rather than duplicate it
    assign fill_idx = fill_hit ? fill_hit_idx : rr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[fill_idx] <= 1'b1;
            rr_q              <= rr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid && !flush) begin
            ent_q[fill_idx] <= fill_entry;
        end
    end

endmodule

// File: hw/pte_checker.sv
`timescale 1ns/1ps
`include "mmu_consts.svh"

module pte_checker (
    input  mmu_pkg::pte_t         pte,
    input  logic                  superpage,
    input  mmu_pkg::access_t      access,
    input  mmu_pkg::priv_t        priv,
    input  logic                  sum,
    input  logic [`MMU_VA_W-1:0]  va,
    output mmu_pkg::fault_t       fault,
    output logic [`MMU_PA_W-1:0]  pa
);
    import mmu_pkg::*;

    logic [$bits(pte_t)-1:0] bits;
    logic                    f_invalid;
    logic                    f_misaligned;
    logic                    f_priv;
    logic                    f_perm;
    logic                    f_accdirty;

    assign bits = pte;

    // a pointer reaching here is at level 0, so it is invalid too
    assign f_invalid = !bits[`MMU_PTE_V]
                     || (bits[`MMU_PTE_W] && !bits[`MMU_PTE_R])
                     || (!bits[`MMU_PTE_R] && !bits[`MMU_PTE_X]);

    assign f_misaligned = superpage && (pte.ppn[`MMU_VPN_W-1:0] != '0);

    always_comb begin
        case (priv)
            PRIV_USER:  f_priv = !bits[`MMU_PTE_U];
            PRIV_SUPER: f_priv = bits[`MMU_PTE_U] && (!sum || access == ACC_FETCH);
            default:    f_priv = 1'b0;
        endcase
    end

    always_comb begin
        case (access)
            ACC_LOAD:  f_perm = !bits[`MMU_PTE_R];
            ACC_STORE: f_perm = !bits[`MMU_PTE_W];
            ACC_FETCH: f_perm = !bits[`MMU_PTE_X];
            default:   f_perm = 1'b1;
        endcase
    end

    // no hardware a/d update, software fixes these up
    assign f_accdirty = !bits[`MMU_PTE_A] || (access == ACC_STORE && !bits[`MMU_PTE_D]);

    always_comb begin
        if (f_invalid)         fault = FAULT_INVALID;
        else if (f_misaligned) fault = FAULT_MISALIGNED;
        else if (f_priv)       fault = FAULT_PRIV;
        else if (f_perm)       fault = FAULT_PERM;
        else if (f_accdirty)   fault = FAULT_ACCDIRTY;
        else                   fault = FAULT_NONE;
    end

    assign pa = superpage
              ? {pte.ppn[`MMU_PPN_W-1:`MMU_VPN_W], va[`MMU_VPN_W+`MMU_PG_OFF_W-1:0]}
              : {pte.ppn, va[`MMU_PG_OFF_W-1:0]};

endmodule

// File: hw/mmu_pkg.sv
`include "mmu_consts.svh"

package mmu_pkg;

    // same encoding as the mstatus mpp field
    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_SUPER   = 2'd1,
        PRIV_MACHINE = 2'd3
    } priv_t;

    typedef enum logic [1:0] {
        ACC_LOAD  = 2'd0,
        ACC_STORE = 2'd1,
        ACC_FETCH = 2'd2
    } access_t;

    // highest priority first
    typedef enum logic [2:0] {
        FAULT_NONE       = 3'd0,
        FAULT_INVALID    = 3'd1,
        FAULT_MISALIGNED = 3'd2,
        FAULT_PRIV       = 3'd3,
        FAULT_PERM       = 3'd4,
        FAULT_ACCDIRTY   = 3'd5
    } fault_t;

    typedef struct packed {
        logic [`MMU_PPN_W-1:0] ppn;
        logic [1:0]            rsw;
        logic                  d;
        logic                  a;
        logic                  g;
        logic                  u;
        logic                  x;
        logic                  w;
        logic                  r;
        logic                  v;
    } pte_t;

    typedef struct packed {
        logic                    valid;
        logic [2*`MMU_VPN_W-1:0] vpn;
        logic                    superpage;
        pte_t                    pte;
    } tlb_entry_t;

    typedef struct packed {
        logic [`MMU_VA_W-1:0] va;
        access_t              access;
        priv_t                priv;
        logic [31:0]          satp;
        logic                 sum;
    } xlate_req_t;

    typedef struct packed {
        logic [`MMU_PA_W-1:0] pa;
        fault_t               fault;
    } xlate_rsp_t;

endpackage

// File: hw/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// address widths
`define MMU_VA_W        32
`define MMU_PA_W        34

// page geometry for sv32
`define MMU_PPN_W       22
`define MMU_VPN_W       10
`define MMU_PG_OFF_W    12

`define MMU_TLB_ENTRIES 4

// pte flag positions
`define MMU_PTE_V       0
`define MMU_PTE_R       1
`define MMU_PTE_W       2
`define MMU_PTE_X       3
`define MMU_PTE_U       4
`define MMU_PTE_A       6
`define MMU_PTE_D       7

// satp mode bit, 1 selects sv32
`define MMU_SATP_MODE   31

`endif
